//--- list.f
common/md_op_pkg.sv
common/md_data_pkg.sv
verilog/md_issue.sv
md_exec/md_mul.sv
md_exec/md_div.sv
verilog/md_hilo.sv
verilog/md_top.sv
bench/md_checker.sv
bench/md_tb.sv

//--- bench/md_tb.sv
module md_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import md_op_pkg::*;
	import md_data_pkg::*;

	localparam int IDLE_TIMEOUT = 100;

	logic   clk;
	logic   rst;
	md_op_e op_i;
	word_t  a_i;
	word_t  b_i;
	logic   stop_i;
	logic   restore_i;
	logic   busy_o;
	logic   invalid_o;
	word_t  hi_o;
	word_t  lo_o;
	word_t  out_o;
	integer seed;

	// Reference state of HI/LO and the snapshot.
	word_t  exp_hi;
	word_t  exp_lo;
	word_t  snap_hi;
	word_t  snap_lo;

	md_top i_md_top (
		.clk       (clk),
		.rst       (rst),
		.op_i      (op_i),
		.a_i       (a_i),
		.b_i       (b_i),
		.stop_i    (stop_i),
		.restore_i (restore_i),
		.busy_o    (busy_o),
		.invalid_o (invalid_o),
		.hi_o      (hi_o),
		.lo_o      (lo_o),
		.out_o     (out_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_sim(string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_pair(word_t got_hi, word_t got_lo, word_t want_hi, word_t want_lo,
			string what);
		if (got_hi !== want_hi || got_lo !== want_lo) begin
			abort_sim($sformatf("ERR %0t: %s hi %h lo %h, expected hi %h lo %h",
				$time, what, got_hi, got_lo, want_hi, want_lo));
		end
	endtask

	task automatic check_word(word_t got, word_t want, string what);
		if (got !== want) begin
			abort_sim($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, want));
		end
	endtask

	task automatic check_flag(logic got, logic want, string what);
		if (got !== want) begin
			abort_sim($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, want));
		end
	endtask

	function automatic logic [63:0] mul_model(logic sgn, word_t a, word_t b);
		longint sa;
		longint sb;
		logic [63:0] p;
		if (sgn) begin
			sa = longint'($signed(a));
			sb = longint'($signed(b));
			p  = sa * sb;
		end else begin
			p = {32'd0, a} * {32'd0, b};
		end
		return p;
	endfunction

	// 64-bit signed math truncates toward zero and keeps the dividend's sign.
	task automatic div_model(input logic sgn, input word_t a, input word_t b,
			output word_t q, output word_t r);
		longint sa;
		longint sb;
		sa = sgn ? longint'($signed(a)) : longint'({32'd0, a});
		sb = sgn ? longint'($signed(b)) : longint'({32'd0, b});
		q  = word_t'(sa / sb);
		r  = word_t'(sa % sb);
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		@(negedge clk);
		while (busy_o) begin
			if (n >= IDLE_TIMEOUT) begin
				abort_sim("Timeout: busy_o never went low after an operation");
			end
			n++;
			@(negedge clk);
		end
	endtask

	task automatic do_arith(md_op_e op, word_t a, word_t b);
		@(posedge clk);
		op_i <= op;
		a_i  <= a;
		b_i  <= b;
		@(posedge clk);
		op_i <= MD_NONE; // Accepted on this edge.
		wait_idle();
	endtask

	task automatic run_mul(md_op_e op, word_t a, word_t b);
		logic [63:0] p;
		p = mul_model(op == MD_MULT, a, b);
		do_arith(op, a, b);
		exp_hi = p[63:32];
		exp_lo = p[31:0];
		check_pair(hi_o, lo_o, exp_hi, exp_lo, $sformatf("%s %h * %h", op.name(), a, b));
		check_flag(invalid_o, 1'b0, "invalid_o after multiply");
	endtask

	task automatic run_div(md_op_e op, word_t a, word_t b);
		word_t q;
		word_t r;
		div_model(op == MD_DIV, a, b, q, r);
		do_arith(op, a, b);
		exp_hi = r;
		exp_lo = q;
		check_pair(hi_o, lo_o, exp_hi, exp_lo, $sformatf("%s %h / %h", op.name(), a, b));
		check_flag(invalid_o, 1'b0, "invalid_o after divide");
	endtask

	task automatic write_reg(md_op_e op, word_t v);
		@(posedge clk);
		op_i <= op;
		a_i  <= v;
		@(negedge clk);
		check_word(out_o, '0, "out_o during a move");
		@(posedge clk);
		op_i    <= MD_NONE;
		snap_hi = exp_hi;
		snap_lo = exp_lo;
		if (op == MD_MTHI) begin
			exp_hi = v;
		end else begin
			exp_lo = v;
		end
		@(negedge clk);
		check_pair(hi_o, lo_o, exp_hi, exp_lo, $sformatf("after %s", op.name()));
	endtask

	task automatic read_out(md_op_e op, word_t want);
		@(posedge clk);
		op_i <= op;
		@(negedge clk);
		check_word(out_o, want, $sformatf("out_o for %s", op.name()));
		@(posedge clk);
		op_i <= MD_NONE;
	endtask

	task automatic do_restore();
		@(posedge clk);
		restore_i <= 1'b1;
		@(posedge clk);
		restore_i <= 1'b0;
		exp_hi = snap_hi;
		exp_lo = snap_lo;
		@(negedge clk);
		check_pair(hi_o, lo_o, exp_hi, exp_lo, "after restore");
	endtask

	task automatic test_mul();
		word_t corner [7];
		word_t a;
		word_t b;
		int    i;
		int    j;
		corner = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000, 32'h7fffffff,
			32'hfffffff9, 32'h12345678};
		for (i = 0; i < 7; i++) begin
			for (j = 0; j < 7; j++) begin
				run_mul(MD_MULT, corner[i], corner[j]);
				run_mul(MD_MULTU, corner[i], corner[j]);
			end
		end
		for (i = 0; i < 20; i++) begin
			a = $random(seed);
			b = $random(seed);
			run_mul(MD_MULT, a, b);
			run_mul(MD_MULTU, a, b);
		end
	endtask

	task automatic test_div();
		word_t corner [7];
		word_t a;
		word_t b;
		int    i;
		int    j;
		corner = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000, 32'h7fffffff,
			32'hfffffff9, 32'h12345678};
		for (i = 0; i < 7; i++) begin
			for (j = 1; j < 7; j++) begin
				run_div(MD_DIV, corner[i], corner[j]);
				run_div(MD_DIVU, corner[i], corner[j]);
			end
		end
		run_div(MD_DIV, 32'd7, 32'd2);
		run_div(MD_DIV, 32'd7, 32'hfffffffe);
		for (i = 0; i < 20; i++) begin
			a = $random(seed);
			b = $random(seed);
			if (b == '0) begin
				b = 32'd3;
			end
			run_div(MD_DIV, a, b);
			run_div(MD_DIVU, a, b);
		end
	endtask

	task automatic test_div_zero();
		run_mul(MD_MULT, 32'h00001234, 32'h00005678);
		do_arith(MD_DIV, 32'h00000005, 32'h0);
		check_pair(hi_o, lo_o, exp_hi, exp_lo, "HI/LO after DIV by zero");
		check_flag(invalid_o, 1'b1, "invalid_o after DIV by zero");
		do_arith(MD_DIVU, 32'hffffffff, 32'h0);
		check_pair(hi_o, lo_o, exp_hi, exp_lo, "HI/LO after DIVU by zero");
		check_flag(invalid_o, 1'b1, "invalid_o after DIVU by zero");
		run_mul(MD_MULT, 32'hfffffffd, 32'h00000011); // Also clears invalid.
	endtask

	task automatic test_move();
		write_reg(MD_MTHI, 32'hcafe0001);
		write_reg(MD_MTLO, 32'h0badf00d);
		read_out(MD_MFHI, exp_hi);
		read_out(MD_MFLO, exp_lo);
		read_out(MD_NONE, '0);
	endtask

	task automatic test_restore();
		write_reg(MD_MTHI, 32'h11112222);
		do_restore();
		write_reg(MD_MTHI, 32'h33334444);
		write_reg(MD_MTLO, 32'h55556666);
		do_restore(); // Back to the pair seen before the MTLO.
	endtask

	task automatic stop_op(md_op_e op, word_t a, word_t b);
		@(posedge clk);
		op_i <= op;
		a_i  <= a;
		b_i  <= b;
		@(posedge clk);
		op_i <= MD_NONE;
		repeat (6) @(posedge clk);
		stop_i <= 1'b1;
		@(posedge clk);
		stop_i <= 1'b0;
		wait_idle();
		check_pair(hi_o, lo_o, exp_hi, exp_lo, $sformatf("HI/LO after stopped %s", op.name()));
	endtask

	task automatic test_stop();
		stop_op(MD_MULT, 32'h00000100, 32'h00000200);
		stop_op(MD_DIVU, 32'h00010000, 32'h00000010);
		run_mul(MD_MULT, 32'h80000000, 32'h00000003);
		run_div(MD_DIV, 32'hffff0000, 32'h00000007);
	endtask

	initial begin
		seed      = 32'hdb1a;
		rst       = 1'b1;
		op_i      = MD_NONE;
		a_i       = '0;
		b_i       = '0;
		stop_i    = 1'b0;
		restore_i = 1'b0;
		exp_hi    = '0;
		exp_lo    = '0;
		snap_hi   = '0;
		snap_lo   = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_flag(busy_o, 1'b0, "busy_o after reset");
		check_flag(invalid_o, 1'b0, "invalid_o after reset");
		check_pair(hi_o, lo_o, '0, '0, "HI/LO after reset");
		test_mul();
		test_div();
		test_div_zero();
		test_move();
		test_restore();
		test_stop();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- bench/md_checker.sv
module md_checker (
	input logic clk,
	input logic rst,
	input logic stop_i,
	input logic busy_i,
	input logic done_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// Unit comes out of reset idle.
	a_reset_idle: assert property (
		@(posedge clk) rst |=> !busy_i
	) else $error("busy high in the cycle after reset");

	// Abort drops the running flag at the next edge.
	a_stop_idle: assert property (
		@(posedge clk) disable iff (rst)
		stop_i |-> ##[1:2] !busy_i
	) else $error("busy still high two cycles after stop");

	// Execute units only finish work that was accepted.
	a_done_busy: assert property (
		@(posedge clk) disable iff (rst)
		done_i |-> busy_i
	) else $error("done pulse while the unit is idle");

endmodule

bind md_issue md_checker i_md_checker (
	.clk    (clk),
	.rst    (rst),
	.stop_i (stop_i),
	.busy_i (busy_o),
	.done_i (mul_done_i || div_done_i)
);

//--- verilog/md_top.sv
module md_top (
	input  logic               clk,
	input  logic               rst,
	input  md_op_pkg::md_op_e  op_i,
	input  md_data_pkg::word_t a_i,
	input  md_data_pkg::word_t b_i,
	input  logic               stop_i,
	input  logic               restore_i,
	output logic               busy_o,
	output logic               invalid_o,
	output md_data_pkg::word_t hi_o,
	output md_data_pkg::word_t lo_o,
	output md_data_pkg::word_t out_o
);
	import md_data_pkg::*;

	md_req_t req;
	md_res_t mul_res;
	md_res_t div_res;

	md_issue i_md_issue (
		.clk        (clk),
		.rst        (rst),
		.op_i       (op_i),
		.a_i        (a_i),
		.b_i        (b_i),
		.stop_i     (stop_i),
		.restore_i  (restore_i),
		.mul_done_i (mul_res.done),
		.div_done_i (div_res.done),
		.req_o      (req),
		.busy_o     (busy_o)
	);

	md_mul i_md_mul (
		.clk     (clk),
		.rst     (rst),
		.req_i   (req),
		.abort_i (stop_i),
		.res_o   (mul_res)
	);

	md_div i_md_div (
		.clk     (clk),
		.rst     (rst),
		.req_i   (req),
		.abort_i (stop_i),
		.res_o   (div_res)
	);

	md_hilo i_md_hilo (
		.clk       (clk),
		.rst       (rst),
		.op_i      (op_i),
		.a_i       (a_i),
		.busy_i    (busy_o),
		.restore_i (restore_i),
		.stop_i    (stop_i),
		.mul_res_i (mul_res),
		.div_res_i (div_res),
		.hi_o      (hi_o),
		.lo_o      (lo_o),
		.out_o     (out_o),
		.invalid_o (invalid_o)
	);

endmodule

//--- verilog/md_hilo.sv
module md_hilo (
	input  logic                 clk,
	input  logic                 rst,
	input  md_op_pkg::md_op_e    op_i,
	input  md_data_pkg::word_t   a_i,
	input  logic                 busy_i,
	input  logic                 restore_i,
	input  logic                 stop_i,
	input  md_data_pkg::md_res_t mul_res_i,
	input  md_data_pkg::md_res_t div_res_i,
	output md_data_pkg::word_t   hi_o,
	output md_data_pkg::word_t   lo_o,
	output md_data_pkg::word_t   out_o,
	output logic                 invalid_o
);
	import md_op_pkg::*;
	import md_data_pkg::*;

	md_res_t res;
	logic    commit;
	logic    zero_hit;
	logic    mt_ok;
	word_t   hi_q;
	word_t   lo_q;
	word_t   snap_hi_q;
	word_t   snap_lo_q;
	logic    invalid_q;

	assign res      = mul_res_i.done ? mul_res_i : div_res_i; // One unit at a time.
	assign commit   = res.done && !res.div_zero && !stop_i;
	assign zero_hit = res.done && res.div_zero && !stop_i;
	assign mt_ok    = !busy_i && !stop_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			hi_q      <= '0;
			lo_q      <= '0;
			snap_hi_q <= '0;
			snap_lo_q <= '0;
		end else if (restore_i) begin
			hi_q <= snap_hi_q;
			lo_q <= snap_lo_q;
		end else if (commit) begin
			hi_q <= res.hi;
			lo_q <= res.lo;
		end else if (mt_ok && op_i == MD_MTHI) begin
			hi_q      <= a_i;
			snap_hi_q <= hi_q;
			snap_lo_q <= lo_q;
		end else if (mt_ok && op_i == MD_MTLO) begin
			lo_q      <= a_i;
			snap_hi_q <= hi_q;
			snap_lo_q <= lo_q;
		end
	end

	// Set wins over clear; a new op is never accepted in the done cycle.
	always_ff @(posedge clk) begin
		if (rst) begin
			invalid_q <= 1'b0;
		end else if (zero_hit) begin
			invalid_q <= 1'b1;
		end else if (md_is_arith(op_i) && !stop_i && !restore_i) begin
			invalid_q <= 1'b0;
		end
	end

	always_comb begin
		case (op_i)
			MD_MFHI: out_o = hi_q;
			MD_MFLO: out_o = lo_q;
			default: out_o = '0;
		endcase
	end

	assign hi_o      = hi_q;
	assign lo_o      = lo_q;
	assign invalid_o = invalid_q;

endmodule

//--- md_exec/md_div.sv
module md_div (
	input  logic                 clk,
	input  logic                 rst,
	input  md_data_pkg::md_req_t req_i,
	input  logic                 abort_i,
	output md_data_pkg::md_res_t res_o
);
	import md_op_pkg::*;
	import md_data_pkg::*;

	logic        start;
	logic        run_q;
	logic        done_q;
	md_step_t    cnt_q;
	logic        qneg_q;
	logic        rneg_q;
	logic        zero_q;
	word_t       dvd_q;
	word_t       dvs_q;
	word_t       rem_q;
	logic [33:0] trial;

	assign start = req_i.start && req_i.is_div;

	// Shift in the next dividend bit and try the subtraction.
	assign trial = {1'b0, rem_q, dvd_q[31]} - {2'b00, dvs_q};

	always_ff @(posedge clk) begin
		if (rst) begin
			run_q  <= 1'b0;
			done_q <= 1'b0;
			cnt_q  <= '0;
		end else if (abort_i) begin
			run_q  <= 1'b0;
			done_q <= 1'b0;
			cnt_q  <= '0;
		end else begin
			done_q <= 1'b0;
			if (start) begin
				run_q <= 1'b1;
				cnt_q <= '0;
			end else if (run_q) begin
				cnt_q <= cnt_q + md_step_t'(1);
				if (cnt_q == md_step_t'(MD_STEPS + 1)) begin
					run_q  <= 1'b0;
					done_q <= 1'b1; // Output edge.
				end
			end
		end
	end

	// Dividend register fills with quotient bits from the right.
	always_ff @(posedge clk) begin
		if (start) begin
			dvd_q  <= md_mag(req_i.a, req_i.is_signed);
			dvs_q  <= md_mag(req_i.b, req_i.is_signed);
			rem_q  <= '0;
			qneg_q <= req_i.is_signed && (req_i.a[31] ^ req_i.b[31]);
			rneg_q <= req_i.is_signed && req_i.a[31];
			zero_q <= (req_i.b == '0);
		end else if (run_q && cnt_q < md_step_t'(MD_STEPS)) begin
			dvd_q <= {dvd_q[30:0], ~trial[33]};
			if (trial[33]) begin
				rem_q <= {rem_q[30:0], dvd_q[31]}; // Restore.
			end else begin
				rem_q <= trial[31:0];
			end
		end else if (run_q && cnt_q == md_step_t'(MD_STEPS)) begin
			dvd_q <= qneg_q ? -dvd_q : dvd_q;
			rem_q <= rneg_q ? -rem_q : rem_q; // Remainder follows dividend.
		end
	end

	assign res_o = '{done: done_q, div_zero: zero_q, hi: rem_q, lo: dvd_q};

endmodule

//--- md_exec/md_mul.sv
module md_mul (
	input  logic                 clk,
	input  logic                 rst,
	input  md_data_pkg::md_req_t req_i,
	input  logic                 abort_i,
	output md_data_pkg::md_res_t res_o
);
	import md_op_pkg::*;
	import md_data_pkg::*;

	logic        start;
	logic        last;
	logic        run_q;
	logic        done_q;
	md_step_t    cnt_q;
	logic        neg_q;
	word_t       mcand_q;
	logic [63:0] prod_q;
	logic [32:0] sum;

	assign start = req_i.start && !req_i.is_div;
	assign last  = (cnt_q == md_step_t'(MD_STEPS));

	// Add multiplicand to the upper half when the current multiplier bit is set.
	assign sum = {1'b0, prod_q[63:32]} + (prod_q[0] ? {1'b0, mcand_q} : 33'd0);

	always_ff @(posedge clk) begin
		if (rst) begin
			run_q  <= 1'b0;
			done_q <= 1'b0;
			cnt_q  <= '0;
		end else if (abort_i) begin
			run_q  <= 1'b0;
			done_q <= 1'b0;
			cnt_q  <= '0;
		end else begin
			done_q <= 1'b0;
			if (start) begin
				run_q <= 1'b1;
				cnt_q <= '0;
			end else if (run_q) begin
				if (last) begin
					run_q  <= 1'b0;
					done_q <= 1'b1; // Fix-up edge.
				end else begin
					cnt_q <= cnt_q + md_step_t'(1);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			mcand_q <= md_mag(req_i.a, req_i.is_signed);
			prod_q  <= {32'd0, md_mag(req_i.b, req_i.is_signed)};
			neg_q   <= req_i.is_signed && (req_i.a[31] ^ req_i.b[31]);
		end else if (run_q && !last) begin
			prod_q <= {sum, prod_q[31:1]};
		end else if (run_q) begin
			prod_q <= neg_q ? -prod_q : prod_q;
		end
	end

	assign res_o = '{done: done_q, div_zero: 1'b0, hi: prod_q[63:32], lo: prod_q[31:0]};

endmodule

//--- verilog/md_issue.sv
module md_issue (
	input  logic                 clk,
	input  logic                 rst,
	input  md_op_pkg::md_op_e    op_i,
	input  md_data_pkg::word_t   a_i,
	input  md_data_pkg::word_t   b_i,
	input  logic                 stop_i,
	input  logic                 restore_i,
	input  logic                 mul_done_i,
	input  logic                 div_done_i,
	output md_data_pkg::md_req_t req_o,
	output logic                 busy_o
);
	import md_op_pkg::*;
	import md_data_pkg::*;

	logic  arith;
	logic  accept;
	logic  running_q;
	logic  start_q;
	logic  is_div_q;
	logic  is_signed_q;
	word_t a_q;
	word_t b_q;

	assign arith  = md_is_arith(op_i);
	assign accept = arith && !running_q && !stop_i && !restore_i;
	assign busy_o = running_q || arith; // CPU stalls on a new op too.

	always_ff @(posedge clk) begin
		if (rst) begin
			running_q <= 1'b0;
			start_q   <= 1'b0;
		end else begin
			start_q <= accept;
			if (stop_i) begin
				running_q <= 1'b0;
			end else if (accept) begin
				running_q <= 1'b1;
			end else if (mul_done_i || div_done_i) begin
				running_q <= 1'b0; // Result commits this edge.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			is_div_q    <= md_is_div(op_i);
			is_signed_q <= md_is_signed(op_i);
			a_q         <= a_i;
			b_q         <= b_i;
		end
	end

	assign req_o = '{
		start:     start_q,
		is_div:    is_div_q,
		is_signed: is_signed_q,
		a:         a_q,
		b:         b_q
	};

endmodule

//--- common/md_data_pkg.sv
package md_data_pkg;

	typedef logic [31:0] word_t;

	// Issue to execute.
	typedef struct packed {
		logic  start;
		logic  is_div;
		logic  is_signed;
		word_t a;
		word_t b;
	} md_req_t;

	// Execute to HI/LO.
	typedef struct packed {
		logic  done;
		logic  div_zero;
		word_t hi;
		word_t lo;
	} md_res_t;

	// Magnitude of a word, two's complement when signed.
	function automatic word_t md_mag(word_t w, logic is_signed);
		return (is_signed && w[31]) ? -w : w;
	endfunction

endpackage

//--- common/md_op_pkg.sv
package md_op_pkg;

	localparam int MD_STEPS = 32; // Iterations of multiplier and divider.

	typedef logic [5:0] md_step_t;

	typedef enum logic [3:0] {
		MD_NONE  = 4'd0,
		MD_MULT  = 4'd1,
		MD_MULTU = 4'd2,
		MD_DIV   = 4'd3,
		MD_DIVU  = 4'd4,
		MD_MFHI  = 4'd5,
		MD_MFLO  = 4'd6,
		MD_MTHI  = 4'd7,
		MD_MTLO  = 4'd8
	} md_op_e;

	function automatic logic md_is_arith(md_op_e op);
		return op == MD_MULT || op == MD_MULTU || op == MD_DIV || op == MD_DIVU;
	endfunction

	function automatic logic md_is_div(md_op_e op);
		return op == MD_DIV || op == MD_DIVU;
	endfunction

	function automatic logic md_is_signed(md_op_e op);
		return op == MD_MULT || op == MD_DIV;
	endfunction

endpackage
